// ==== design/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_alu import ex_pkg::*; (
    input  alu_ctrl_t           ctrl,
    input  logic [`EX_XLEN-1:0] src_a,
    input  logic [`EX_XLEN-1:0] src_b,
    input  logic [`EX_XLEN-1:0] imm,
    input  logic [`EX_XLEN-1:0] pc,
    output logic [`EX_XLEN-1:0] result
);

    logic [`EX_XLEN-1:0] op_a;
    logic [`EX_XLEN-1:0] op_b;
    logic [5:0]          shamt;
    logic [`EX_XLEN-1:0] shr_src;
    logic [`EX_XLEN-1:0] raw;

    always_comb begin
        case (ctrl.a_sel)
            A_PC:    op_a = pc;
            A_ZERO:  op_a = '0;
            default: op_a = src_a;
        endcase
    end

    assign op_b = ctrl.b_sel ? imm : src_b;

    // word shifts only see 5 bits of shamt
    assign shamt = ctrl.word ? {1'b0, op_b[4:0]} : op_b[5:0];

    // right shifts on words start from the low half, extended for the shift kind
    always_comb begin
        shr_src = op_a;
        if (ctrl.word) begin
            if (ctrl.mode == ALU_SRA) begin
                shr_src = {{32{op_a[31]}}, op_a[31:0]};
            end else begin
                shr_src = {32'b0, op_a[31:0]};
            end
        end
    end

    always_comb begin
        case (ctrl.mode)
            ALU_SUB:  raw = op_a - op_b;
            ALU_SLL:  raw = op_a << shamt;
            ALU_SLT:  raw = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: raw = {63'b0, op_a < op_b};
            ALU_XOR:  raw = op_a ^ op_b;
            ALU_SRL:  raw = shr_src >> shamt;
            ALU_SRA:  raw = $signed(shr_src) >>> shamt;
            ALU_OR:   raw = op_a | op_b;
            ALU_AND:  raw = op_a & op_b;
            default:  raw = op_a + op_b;
        endcase
    end

    // low word, sign-extended
    assign result = ctrl.word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== design/ex_branch_unit.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_branch_unit import ex_pkg::*; (
    input  logic                cur_valid,
    input  ex_req_t             cur,
    input  logic [`EX_XLEN-1:0] alu_result,
    output logic [`EX_XLEN-1:0] dnpc,
    output logic                pc_update
);

    localparam logic [`EX_XLEN-1:0] PC_STEP = `EX_PC_STEP;

    logic [`EX_XLEN-1:0] snpc;
    logic                taken;
    logic                redirect;

    // fall-through pc, also 4 for a bubble since pc reads zero
    assign snpc = cur.pc + PC_STEP;

    // compare the register operands, target comes from the alu
    always_comb begin
        case (cur.op)
            OP_BEQ:  taken = cur.src_a == cur.src_b;
            OP_BNE:  taken = cur.src_a != cur.src_b;
            OP_BLT:  taken = $signed(cur.src_a) < $signed(cur.src_b);
            OP_BGE:  taken = $signed(cur.src_a) >= $signed(cur.src_b);
            OP_BLTU: taken = cur.src_a < cur.src_b;
            OP_BGEU: taken = cur.src_a >= cur.src_b;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        dnpc     = snpc;
        redirect = 1'b1;
        case (cur.op)
            OP_JAL:  dnpc = alu_result;
            // jalr target has bit 0 forced low
            OP_JALR: dnpc = {alu_result[`EX_XLEN-1:1], 1'b0};
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                dnpc = taken ? alu_result : snpc;
            end
            // trap vector or mepc arrive in src_b
            OP_ECALL, OP_MRET: dnpc = cur.src_b;
            default: redirect = 1'b0;
        endcase
    end

    // not-taken branches still report, fetch takes dnpc as is
    assign pc_update = cur_valid & redirect;

endmodule

// ==== design/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath and pc width
`define EX_XLEN 64

// raw instruction width
`define EX_ILEN 32

// machine-mode csr addresses, compared against inst[31:20]
`define EX_CSR_MTVEC   12'h305
`define EX_CSR_MEPC    12'h341
`define EX_CSR_MCAUSE  12'h342
`define EX_CSR_MSTATUS 12'h300

// mcause code for an environment call from m-mode
`define EX_CAUSE_ECALL_M 11

// sequential fetch step, no compressed instructions
`define EX_PC_STEP 4

`endif

// ==== design/ex_csr_write.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_csr_write import ex_pkg::*; (
    input  ex_req_t             cur,
    input  logic [`EX_XLEN-1:0] alu_result,
    output csr_wr_t             csr_wr
);

    localparam logic [`EX_XLEN-1:0] ECALL_CAUSE = `EX_CAUSE_ECALL_M;

    logic [11:0]         csr_addr;
    logic                is_rw;
    logic                is_rs;
    logic                is_ecall;
    logic [`EX_XLEN-1:0] wr_data;

    // csr address is the i-type immediate field
    assign csr_addr = cur.inst[31:20];
    assign is_rw    = cur.op == OP_CSRRW;
    assign is_rs    = cur.op == OP_CSRRS;
    assign is_ecall = cur.op == OP_ECALL;

    // csrrw writes rs1, csrrs writes rs1 | old value
    assign wr_data = is_rw ? cur.src_a : alu_result;

    always_comb begin
        // mtvec only through csrrw
        csr_wr.mtvec_wen  = is_rw && csr_addr == `EX_CSR_MTVEC;
        csr_wr.mtvec_data = csr_wr.mtvec_wen ? wr_data : '0;

        // ecall saves the trapping pc
        csr_wr.mepc_wen  = is_ecall || ((is_rw || is_rs) && csr_addr == `EX_CSR_MEPC);
        csr_wr.mepc_data = '0;
        if (is_ecall) begin
            csr_wr.mepc_data = cur.pc;
        end else if (csr_wr.mepc_wen) begin
            csr_wr.mepc_data = wr_data;
        end

        csr_wr.mcause_wen  = is_ecall || ((is_rw || is_rs) && csr_addr == `EX_CSR_MCAUSE);
        csr_wr.mcause_data = '0;
        if (is_ecall) begin
            csr_wr.mcause_data = ECALL_CAUSE;
        end else if (csr_wr.mcause_wen) begin
            csr_wr.mcause_data = wr_data;
        end

        // mret leaves mstatus alone here
        csr_wr.mstatus_wen  = (is_rw || is_rs) && csr_addr == `EX_CSR_MSTATUS;
        csr_wr.mstatus_data = csr_wr.mstatus_wen ? wr_data : '0;
    end

endmodule

// ==== design/ex_op_decode.sv ====
`timescale 1ns/1ps

module ex_op_decode import ex_pkg::*; (
    input  ex_op_e    op,
    output alu_ctrl_t ctrl
);

    always_comb begin
        // src_a op src_b, 64-bit add
        ctrl.a_sel = A_SRC_A;
        ctrl.b_sel = 1'b0;
        ctrl.mode  = ALU_ADD;
        ctrl.word  = 1'b0;

        case (op)
            // register-register
            OP_ADD:  ctrl.mode = ALU_ADD;
            OP_SUB:  ctrl.mode = ALU_SUB;
            OP_SLL:  ctrl.mode = ALU_SLL;
            OP_SLT:  ctrl.mode = ALU_SLT;
            OP_SLTU: ctrl.mode = ALU_SLTU;
            OP_XOR:  ctrl.mode = ALU_XOR;
            OP_SRL:  ctrl.mode = ALU_SRL;
            OP_SRA:  ctrl.mode = ALU_SRA;
            OP_OR:   ctrl.mode = ALU_OR;
            OP_AND:  ctrl.mode = ALU_AND;

            // register-immediate, shamt already sits in imm
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI,
            OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI: begin
                ctrl.b_sel = 1'b1;
                case (op)
                    OP_SLTI:  ctrl.mode = ALU_SLT;
                    OP_SLTIU: ctrl.mode = ALU_SLTU;
                    OP_XORI:  ctrl.mode = ALU_XOR;
                    OP_ORI:   ctrl.mode = ALU_OR;
                    OP_ANDI:  ctrl.mode = ALU_AND;
                    OP_SLLI:  ctrl.mode = ALU_SLL;
                    OP_SRLI:  ctrl.mode = ALU_SRL;
                    OP_SRAI:  ctrl.mode = ALU_SRA;
                    default:  ctrl.mode = ALU_ADD;
                endcase
            end

            // word ops, result gets sign-extended in the alu
            OP_ADDW: ctrl.word = 1'b1;
            OP_SUBW: begin
                ctrl.mode = ALU_SUB;
                ctrl.word = 1'b1;
            end
            OP_ADDIW: begin
                ctrl.b_sel = 1'b1;
                ctrl.word  = 1'b1;
            end
            OP_SLLW: begin
                ctrl.mode = ALU_SLL;
                ctrl.word = 1'b1;
            end
            OP_SRLW: begin
                ctrl.mode = ALU_SRL;
                ctrl.word = 1'b1;
            end
            OP_SRAW: begin
                ctrl.mode = ALU_SRA;
                ctrl.word = 1'b1;
            end

            // lui is 0 + imm
            OP_LUI: begin
                ctrl.a_sel = A_ZERO;
                ctrl.b_sel = 1'b1;
            end
            // pc-relative targets, branch condition lives in the branch unit
            OP_AUIPC, OP_JAL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                ctrl.a_sel = A_PC;
                ctrl.b_sel = 1'b1;
            end
            OP_JALR: ctrl.b_sel = 1'b1;

            // set bits, src_b holds the old csr value
            OP_CSRRS: ctrl.mode = ALU_OR;

            // csrrw, ecall, mret, nop keep the default
            default: ;
        endcase
    end

endmodule

// ==== design/ex_pkg.sv ====
`include "ex_config.svh"

package ex_pkg;

    // execute opcodes, zero is the bubble
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        // register-register
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // register-immediate
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        // 32-bit word ops
        OP_ADDW, OP_SUBW, OP_ADDIW, OP_SLLW, OP_SRLW, OP_SRAW,
        // upper immediates and jumps
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        // conditional branches
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // csr and trap
        OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET
    } ex_op_e;

    // alu function
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_mode_e;

    // first operand source
    typedef enum logic [1:0] {
        A_SRC_A,
        A_PC,
        A_ZERO
    } a_sel_e;

    // decode -> execute, csr read value / trap vector ride in src_b
    typedef struct packed {
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_ILEN-1:0] inst;
        ex_op_e              op;
        logic [`EX_XLEN-1:0] src_a;
        logic [`EX_XLEN-1:0] src_b;
        logic [`EX_XLEN-1:0] imm;
    } ex_req_t;

    // execute -> memory
    typedef struct packed {
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_ILEN-1:0] inst;
        ex_op_e              op;
        logic [`EX_XLEN-1:0] alu_out;
        logic [`EX_XLEN-1:0] src_b;
    } ex_resp_t;

    // decoder -> alu, b_sel high picks imm
    typedef struct packed {
        a_sel_e    a_sel;
        logic      b_sel;
        alu_mode_e mode;
        logic      word;
    } alu_ctrl_t;

    // csr write side, data is zero when its enable is low
    typedef struct packed {
        logic               mtvec_wen;
        logic [`EX_XLEN-1:0] mtvec_data;
        logic               mepc_wen;
        logic [`EX_XLEN-1:0] mepc_data;
        logic               mcause_wen;
        logic [`EX_XLEN-1:0] mcause_data;
        logic               mstatus_wen;
        logic [`EX_XLEN-1:0] mstatus_data;
    } csr_wr_t;

endpackage

// ==== design/ex_stage_reg.sv ====
`timescale 1ns/1ps

module ex_stage_reg import ex_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  ex_req_t in_req,
    input  logic    out_ready,
    output logic    in_ready,
    output logic    cur_valid,
    output ex_req_t cur
);

    logic    valid_q;
    ex_req_t req_q;

    // stall comes straight from the memory stage
    assign in_ready = out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            req_q   <= '0;
        end else if (in_ready) begin
            // bubbles load as well, valid travels with them
            valid_q <= in_valid;
            req_q   <= in_req;
        end
    end

    assign cur_valid = valid_q;

    // invalid entry reads as nop with zero fields
    // so nothing downstream has to look at valid
    always_comb begin
        cur = '0;
        if (valid_q) begin
            cur = req_q;
        end
    end

endmodule

// ==== design/ex_top.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_top import ex_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  ex_req_t             in_req,
    output logic                out_valid,
    input  logic                out_ready,
    output ex_resp_t            out_resp,
    output logic [`EX_XLEN-1:0] dnpc,
    output logic                pc_update,
    output csr_wr_t             csr_wr
);

    logic                cur_valid;
    ex_req_t             cur;
    alu_ctrl_t           ctrl;
    logic [`EX_XLEN-1:0] alu_result;

    // the one pipeline entry, masked when invalid
    ex_stage_reg u_stage_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .cur_valid (cur_valid),
        .cur       (cur)
    );

    ex_op_decode u_op_decode (
        .op   (cur.op),
        .ctrl (ctrl)
    );

    ex_alu u_alu (
        .ctrl   (ctrl),
        .src_a  (cur.src_a),
        .src_b  (cur.src_b),
        .imm    (cur.imm),
        .pc     (cur.pc),
        .result (alu_result)
    );

    // next pc for jumps, branches and traps
    ex_branch_unit u_branch_unit (
        .cur_valid  (cur_valid),
        .cur        (cur),
        .alu_result (alu_result),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    ex_csr_write u_csr_write (
        .cur        (cur),
        .alu_result (alu_result),
        .csr_wr     (csr_wr)
    );

    // towards memory, valid is the stored level
    assign out_valid        = cur_valid;
    assign out_resp.pc      = cur.pc;
    assign out_resp.inst    = cur.inst;
    assign out_resp.op      = cur.op;
    assign out_resp.alu_out = alu_result;
    assign out_resp.src_b   = cur.src_b;

endmodule

// ==== project.f ====
+incdir+design
design/ex_pkg.sv
design/ex_stage_reg.sv
design/ex_op_decode.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_csr_write.sv
design/ex_top.sv
tests/ex_checker.sv
tests/ex_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
set -o pipefail 2>/dev/null || true

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f project.f --top-module ex_top_tb -o ex_sim

./obj_dir/ex_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// ==== tests/ex_checker.sv ====
`timescale 1ns/1ps

module ex_checker import ex_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    in_ready,
    input logic    out_ready,
    input logic    out_valid,
    input logic    pc_update,
    input csr_wr_t csr_wr
);

    logic any_csr_wen;

    assign any_csr_wen = csr_wr.mtvec_wen | csr_wr.mepc_wen
                       | csr_wr.mcause_wen | csr_wr.mstatus_wen;

    // stall passes straight through
    a_ready_follows: assert property (@(posedge clk) in_ready == out_ready)
        else $error("in_ready differs from out_ready");

    // register is empty once reset has been seen
    a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_redirect_valid: assert property (@(posedge clk) disable iff (rst) pc_update |-> out_valid)
        else $error("pc_update high without out_valid");

    // csr side effects only from a real instruction
    a_csr_valid: assert property (@(posedge clk) disable iff (rst) any_csr_wen |-> out_valid)
        else $error("csr write enable high without out_valid");

endmodule

bind ex_top ex_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .pc_update (pc_update),
    .csr_wr    (csr_wr)
);

// ==== tests/ex_top_tb.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_top_tb import ex_pkg::*; ();

    localparam int NUM_CYCLES  = 3000;
    localparam int RST_TIMEOUT = 50;

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    ex_req_t             in_req;
    logic                out_valid;
    logic                out_ready;
    ex_resp_t            out_resp;
    logic [`EX_XLEN-1:0] dnpc;
    logic                pc_update;
    csr_wr_t             csr_wr;

    // lcg state
    logic [31:0] seed;

    // model copy of the pipeline entry
    logic    m_valid;
    ex_req_t m_req;

    int value_errors;
    int other_errors;
    int cnt_mtvec;
    int cnt_mepc;
    int cnt_mcause;
    int cnt_mstatus;
    int cnt_stall;

    ex_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_resp  (out_resp),
        .dnpc      (dnpc),
        .pc_update (pc_update),
        .csr_wr    (csr_wr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // upper halves of two lcg steps, the low state bits repeat with a short period
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = seed[31:16];
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi, seed[31:16]};
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // expected alu output straight from the isa rules
    function automatic logic [63:0] model_alu(input ex_req_t r);
        logic [63:0]        a;
        logic [63:0]        b;
        logic [63:0]        i;
        logic signed [31:0] aw;
        a  = r.src_a;
        b  = r.src_b;
        i  = r.imm;
        aw = r.src_a[31:0];
        case (r.op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLL:   return a << b[5:0];
            OP_SLT:   return {63'b0, $signed(a) < $signed(b)};
            OP_SLTU:  return {63'b0, a < b};
            OP_XOR:   return a ^ b;
            OP_SRL:   return a >> b[5:0];
            OP_SRA:   return $signed(a) >>> b[5:0];
            OP_OR:    return a | b;
            OP_AND:   return a & b;
            OP_ADDI:  return a + i;
            OP_SLTI:  return {63'b0, $signed(a) < $signed(i)};
            OP_SLTIU: return {63'b0, a < i};
            OP_XORI:  return a ^ i;
            OP_ORI:   return a | i;
            OP_ANDI:  return a & i;
            OP_SLLI:  return a << i[5:0];
            OP_SRLI:  return a >> i[5:0];
            OP_SRAI:  return $signed(a) >>> i[5:0];
            OP_ADDW:  return sext32(a[31:0] + b[31:0]);
            OP_SUBW:  return sext32(a[31:0] - b[31:0]);
            OP_ADDIW: return sext32(a[31:0] + i[31:0]);
            OP_SLLW:  return sext32(a[31:0] << b[4:0]);
            OP_SRLW:  return sext32(a[31:0] >> b[4:0]);
            OP_SRAW:  return sext32(aw >>> b[4:0]);
            OP_LUI:   return i;
            OP_JALR:  return a + i;
            OP_AUIPC, OP_JAL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                return r.pc + i;
            OP_CSRRS: return a | b;
            default:  return a + b;
        endcase
    endfunction

    function automatic logic branch_taken(input ex_req_t r);
        case (r.op)
            OP_BEQ:  return r.src_a == r.src_b;
            OP_BNE:  return r.src_a != r.src_b;
            OP_BLT:  return $signed(r.src_a) < $signed(r.src_b);
            OP_BGE:  return $signed(r.src_a) >= $signed(r.src_b);
            OP_BLTU: return r.src_a < r.src_b;
            OP_BGEU: return r.src_a >= r.src_b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // compare every dut output against the model entry
    task automatic check_outputs();
        ex_req_t     r;
        logic [63:0] alu;
        logic [63:0] snpc;
        logic [63:0] e_dnpc;
        logic        e_upd;
        logic        is_csr;
        logic [63:0] wdata;
        logic [11:0] addr;
        csr_wr_t     e_csr;
        r      = m_valid ? m_req : '0;
        alu    = model_alu(r);
        snpc   = r.pc + 64'd`EX_PC_STEP;
        e_dnpc = snpc;
        e_upd  = 1'b1;
        case (r.op)
            OP_JAL:  e_dnpc = alu;
            OP_JALR: e_dnpc = alu & ~64'd1;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                e_dnpc = branch_taken(r) ? alu : snpc;
            OP_ECALL, OP_MRET: e_dnpc = r.src_b;
            default: e_upd = 1'b0;
        endcase
        e_upd  = e_upd & m_valid;
        is_csr = r.op == OP_CSRRW || r.op == OP_CSRRS;
        wdata  = r.op == OP_CSRRW ? r.src_a : (r.src_a | r.src_b);
        addr   = r.inst[31:20];
        e_csr  = '0;
        if (r.op == OP_CSRRW && addr == `EX_CSR_MTVEC) begin
            e_csr.mtvec_wen  = 1'b1;
            e_csr.mtvec_data = wdata;
        end
        if (is_csr && addr == `EX_CSR_MEPC) begin
            e_csr.mepc_wen  = 1'b1;
            e_csr.mepc_data = wdata;
        end
        if (is_csr && addr == `EX_CSR_MCAUSE) begin
            e_csr.mcause_wen  = 1'b1;
            e_csr.mcause_data = wdata;
        end
        if (is_csr && addr == `EX_CSR_MSTATUS) begin
            e_csr.mstatus_wen  = 1'b1;
            e_csr.mstatus_data = wdata;
        end
        // ecall saves pc and the m-mode cause
        if (r.op == OP_ECALL) begin
            e_csr.mepc_wen    = 1'b1;
            e_csr.mepc_data   = r.pc;
            e_csr.mcause_wen  = 1'b1;
            e_csr.mcause_data = 64'd`EX_CAUSE_ECALL_M;
        end
        if (!rst) begin
            cnt_mtvec   += int'(e_csr.mtvec_wen);
            cnt_mepc    += int'(e_csr.mepc_wen);
            cnt_mcause  += int'(e_csr.mcause_wen);
            cnt_mstatus += int'(e_csr.mstatus_wen);
        end
        check_val("in_ready", 64'(out_ready), 64'(in_ready));
        check_val("out_valid", 64'(m_valid), 64'(out_valid));
        check_val("out_resp.pc", r.pc, out_resp.pc);
        check_val("out_resp.inst", 64'(r.inst), 64'(out_resp.inst));
        check_val("out_resp.op", 64'(r.op), 64'(out_resp.op));
        check_val("out_resp.alu_out", alu, out_resp.alu_out);
        check_val("out_resp.src_b", r.src_b, out_resp.src_b);
        check_val("dnpc", e_dnpc, dnpc);
        check_val("pc_update", 64'(e_upd), 64'(pc_update));
        check_val("mtvec_wen", 64'(e_csr.mtvec_wen), 64'(csr_wr.mtvec_wen));
        check_val("mtvec_data", e_csr.mtvec_data, csr_wr.mtvec_data);
        check_val("mepc_wen", 64'(e_csr.mepc_wen), 64'(csr_wr.mepc_wen));
        check_val("mepc_data", e_csr.mepc_data, csr_wr.mepc_data);
        check_val("mcause_wen", 64'(e_csr.mcause_wen), 64'(csr_wr.mcause_wen));
        check_val("mcause_data", e_csr.mcause_data, csr_wr.mcause_data);
        check_val("mstatus_wen", 64'(e_csr.mstatus_wen), 64'(csr_wr.mstatus_wen));
        check_val("mstatus_data", e_csr.mstatus_data, csr_wr.mstatus_data);
    endtask

    // one random request plus the stall level
    task automatic drive_random();
        ex_req_t     r;
        logic [31:0] pick;
        logic [11:0] addr;
        r.pc    = rand64() & ~64'd3;
        r.op    = ex_op_e'(6'(next_rand() % 40));
        r.src_a = rand64();
        r.src_b = rand64();
        r.imm   = rand64();
        r.inst  = next_rand();
        pick    = next_rand() % 5;
        case (pick)
            0:       addr = `EX_CSR_MTVEC;
            1:       addr = `EX_CSR_MEPC;
            2:       addr = `EX_CSR_MCAUSE;
            3:       addr = `EX_CSR_MSTATUS;
            default: addr = r.inst[31:20];
        endcase
        r.inst[31:20] = addr;
        // equal operands now and then for beq/bge/bgeu
        if (next_rand() % 3 == 0) begin
            r.src_b = r.src_a;
        end
        in_req    = r;
        in_valid  = (next_rand() % 8) != 0;
        out_ready = (next_rand() % 4) != 0;
    endtask

    // model register, same load rule as the stage
    always @(posedge clk) begin
        if (rst) begin
            m_valid = 1'b0;
            m_req   = '0;
        end else if (out_ready) begin
            m_valid = in_valid;
            m_req   = in_req;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    initial begin
        int wait_cnt;
        seed         = 32'hda4451e3;
        value_errors = 0;
        other_errors = 0;
        cnt_mtvec    = 0;
        cnt_mepc     = 0;
        cnt_mcause   = 0;
        cnt_mstatus  = 0;
        cnt_stall    = 0;
        in_valid     = 1'b0;
        in_req       = '0;
        out_ready    = 1'b1;
        m_valid      = 1'b0;
        m_req        = '0;
        wait_cnt     = 0;
        // reset state is checked on every falling edge until release
        @(negedge clk);
        while (rst) begin
            check_outputs();
            drive_random();
            wait_cnt++;
            if (wait_cnt > RST_TIMEOUT) begin
                $display("timeout waiting for reset release");
                $display("Testbench failed");
                $finish;
            end
            @(negedge clk);
        end
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            check_outputs();
            drive_random();
            if (!out_ready) begin
                cnt_stall++;
            end
            @(negedge clk);
        end
        if (cnt_mtvec == 0 || cnt_mepc == 0 || cnt_mcause == 0 || cnt_mstatus == 0) begin
            $display("some csr was never written during the run");
            other_errors++;
        end
        if (cnt_stall == 0) begin
            $display("out_ready was never low during the run");
            other_errors++;
        end
        $display("errors: value %0d, other %0d (csr writes %0d %0d %0d %0d, stalls %0d)",
                 value_errors, other_errors, cnt_mtvec, cnt_mepc, cnt_mcause, cnt_mstatus,
                 cnt_stall);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
